/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := mdu_tb
FILELIST  := vlog.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Simulation finished: FAIL
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Result: testbench reported a failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Result: run ended without a pass line"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/mdu_ref_model.svh */
`ifndef MDU_REF_MODEL_SVH
`define MDU_REF_MODEL_SVH

// Expected result of one M-extension operation by the RISC-V rules
function automatic logic [31:0] ref_result(input mdu_pkg::mdu_op_e op,
                                           input logic [31:0]      a,
                                           input logic [31:0]      b);
  logic [63:0]        a_sx, b_sx;     // Sign extended operands
  logic [63:0]        a_zx, b_zx;     // Zero extended operands
  logic [63:0]        prod;
  logic signed [31:0] sa, sb;
  logic signed [31:0] quo, rmd;
  logic               by_zero;
  logic               overflow;
  logic [31:0]        res;

  sa       = a;
  sb       = b;
  a_sx     = {{32{a[31]}}, a};
  b_sx     = {{32{b[31]}}, b};
  a_zx     = {32'd0, a};
  b_zx     = {32'd0, b};
  by_zero  = b == 32'd0;
  overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
  prod     = 64'd0;
  res      = 32'd0;
  quo      = 32'sd0;
  rmd      = 32'sd0;
  if (!by_zero && !overflow) begin
    quo = sa / sb;                      // Truncates toward zero
    rmd = sa % sb;
  end

  case (op)
    mdu_pkg::op_mul: begin
      prod = a_zx * b_zx;
      res  = prod[31:0];
    end
    mdu_pkg::op_mulh: begin
      prod = a_sx * b_sx;               // Low 64 bits of the true product
      res  = prod[63:32];
    end
    mdu_pkg::op_mulhsu: begin
      prod = a_sx * b_zx;
      res  = prod[63:32];
    end
    mdu_pkg::op_mulhu: begin
      prod = a_zx * b_zx;
      res  = prod[63:32];
    end
    mdu_pkg::op_div:  res = by_zero ? 32'hffff_ffff : (overflow ? a : quo);
    mdu_pkg::op_divu: res = by_zero ? 32'hffff_ffff : a / b;
    mdu_pkg::op_rem:  res = by_zero ? a : (overflow ? 32'd0 : rmd);
    mdu_pkg::op_remu: res = by_zero ? a : a % b;
    default:          res = 32'd0;
  endcase
  return res;
endfunction

`endif

/* bench/mdu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mdu_tb;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  localparam int RANDOM_COUNT = 200;
  localparam int MUL_LATENCY  = 3;
  localparam int DIV_LATENCY  = 33;
  localparam int MAX_WAIT     = 60;   // Cycles before a handshake counts as lost

  typedef struct packed {
    mdu_pkg::mdu_op_e   op;
    logic [31:0]        a;
    logic [31:0]        b;
    logic [7:0]         flush_after;  // Cycles after acceptance or 0 for none
    logic [7:0]         stall;        // Cycles with resp_ready low
    mdu_pkg::mdu_resp_t expected;
  } stim_t;

  logic               clock = 1'b0;
  logic               reset;
  logic               flush;
  mdu_pkg::mdu_req_t  req;
  logic               req_valid;
  logic               req_ready;
  mdu_pkg::mdu_resp_t resp;
  logic               resp_valid;
  logic               resp_ready;

  stim_t  stim[$];
  integer seed = 32'h75eb;
  bit     table_ready = 1'b0;

  `include "mdu_ref_model.svh"

  mdu_top mdu_top_inst (
    .clock      (clock),
    .reset      (reset),
    .flush      (flush),
    .req        (req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready)
  );

  always #(CLK_PERIOD / 2) clock = ~clock;

  // ==================================================
  // Checks
  // ==================================================
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped");
  endtask

  task automatic compare_resp(input string name, input mdu_pkg::mdu_resp_t expected,
                              input mdu_pkg::mdu_resp_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("** Error at %0t ns: %s expected %h, actual %h",
                          $time, name, expected.result, actual.result));
    end
  endtask

  task automatic compare_cycles(input string name, input int expected, input int actual);
    if (actual != expected) begin
      abort_run($sformatf("** Error at %0t ns: %s expected %0d, actual %0d",
                          $time, name, expected, actual));
    end
  endtask

  task automatic compare_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("** Error at %0t ns: %s expected %b, actual %b",
                          $time, name, expected, actual));
    end
  endtask

  // ==================================================
  // Stimulus table
  // ==================================================
  function automatic void add_entry(input mdu_pkg::mdu_op_e op, input logic [31:0] a,
                                    input logic [31:0] b, input int flush_after,
                                    input int stall);
    stim_t e;
    e.op              = op;
    e.a               = a;
    e.b               = b;
    e.flush_after     = flush_after[7:0];
    e.stall           = stall[7:0];
    e.expected.result = ref_result(op, a, b);
    stim.push_back(e);
  endfunction

  task automatic build_table();
    add_entry(mdu_pkg::op_mul,    32'd3,         32'd7,         0, 0);
    add_entry(mdu_pkg::op_mul,    32'hffffffff,  32'hffffffff,  0, 0);
    add_entry(mdu_pkg::op_mulh,   32'h80000000,  32'h80000000,  0, 0);
    add_entry(mdu_pkg::op_mulh,   32'hffffffff,  32'h00000005,  0, 0);
    add_entry(mdu_pkg::op_mulh,   32'h7fffffff,  32'h80000000,  0, 0);
    add_entry(mdu_pkg::op_mulhsu, 32'hffffffff,  32'hffffffff,  0, 0);
    add_entry(mdu_pkg::op_mulhsu, 32'h80000000,  32'h00000002,  0, 0);
    add_entry(mdu_pkg::op_mulhsu, 32'h12345678,  32'hfedcba98,  0, 0);
    add_entry(mdu_pkg::op_mulhu,  32'hffffffff,  32'hffffffff,  0, 0);
    add_entry(mdu_pkg::op_mulhu,  32'h12345678,  32'h9abcdef0,  0, 0);
    add_entry(mdu_pkg::op_div,    32'd100,       32'd7,         0, 0);
    add_entry(mdu_pkg::op_div,    32'hffffff9c,  32'd7,         0, 0);
    add_entry(mdu_pkg::op_div,    32'd100,       32'hfffffff9,  0, 0);
    add_entry(mdu_pkg::op_div,    32'hffffff9c,  32'hfffffff9,  0, 0);
    add_entry(mdu_pkg::op_div,    32'h80000000,  32'hffffffff,  0, 0);
    add_entry(mdu_pkg::op_div,    32'd5,         32'd0,         0, 0);
    add_entry(mdu_pkg::op_divu,   32'hffffffff,  32'd3,         0, 0);
    add_entry(mdu_pkg::op_divu,   32'd7,         32'd0,         0, 0);
    add_entry(mdu_pkg::op_rem,    32'hffffff9c,  32'd7,         0, 0);
    add_entry(mdu_pkg::op_rem,    32'd100,       32'hfffffff9,  0, 0);
    add_entry(mdu_pkg::op_rem,    32'h80000000,  32'hffffffff,  0, 0);
    add_entry(mdu_pkg::op_rem,    32'd5,         32'd0,         0, 0);
    add_entry(mdu_pkg::op_remu,   32'hffffffff,  32'd10,        0, 0);
    add_entry(mdu_pkg::op_remu,   32'd9,         32'd0,         0, 0);
    add_entry(mdu_pkg::op_mul,    32'd1234,      32'd5678,      0, 5);   // Back-pressure
    add_entry(mdu_pkg::op_div,    32'hfffffff7,  32'd4,         0, 3);
    add_entry(mdu_pkg::op_rem,    32'hfffffff7,  32'd4,         0, 1);
    add_entry(mdu_pkg::op_div,    32'd1000,      32'd3,         10, 0);  // Flushed mid divide
    add_entry(mdu_pkg::op_divu,   32'd1000,      32'd7,         1, 0);
    add_entry(mdu_pkg::op_rem,    32'hfffffff9,  32'd2,         0, 0);
    add_entry(mdu_pkg::op_div,    32'd77,        32'd0,         33, 0);  // Flushed in hold
    add_entry(mdu_pkg::op_mulhu,  32'hdeadbeef,  32'h0badf00d,  0, 0);
    add_entry(mdu_pkg::op_mul,    32'h00010001,  32'h00020003,  2, 0);
    add_entry(mdu_pkg::op_mul,    32'hcafef00d,  32'h13572468,  0, 2);
  endtask

  task automatic add_random_entries();
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    repeat (RANDOM_COUNT) begin
      r = $random(seed);
      a = $random(seed);
      b = $random(seed);
      if (r[5:4] == 2'd0) b = b & 32'h0000_000f;    // Small divisors and zero
      if (r[9:6] == 4'd0) begin
        a = 32'h8000_0000;
        b = 32'hffff_ffff;
      end
      add_entry(mdu_pkg::mdu_op_e'(r[2:0]), a, b, 0, int'(r[11:10]));
    end
  endtask

  function automatic int latency_of(input mdu_pkg::mdu_op_e op);
    if (op inside {mdu_pkg::op_div, mdu_pkg::op_divu, mdu_pkg::op_rem, mdu_pkg::op_remu}) begin
      return DIV_LATENCY;
    end
    return MUL_LATENCY;
  endfunction

  // ==================================================
  // Bus tasks entered on a falling edge
  // ==================================================
  task automatic accept_request(input stim_t e);
    int waited;
    waited    = 0;
    req.op    = e.op;
    req.a     = e.a;
    req.b     = e.b;
    req_valid = 1'b1;
    #1;
    while (!req_ready) begin
      if (waited == MAX_WAIT) abort_run("Request was never accepted by the DUT");
      @(negedge clock);
      #1;
      waited++;
    end
    @(posedge clock);                 // Accepting edge
  endtask

  task automatic collect_response(input stim_t e);
    int cycles;
    cycles = 0;
    @(negedge clock);
    req_valid  = 1'b0;
    flush      = 1'b0;
    resp_ready = e.stall == 8'd0;
    while (!resp_valid) begin
      if (cycles == MAX_WAIT) abort_run("No response arrived for an accepted request");
      @(negedge clock);
      cycles++;
    end
    compare_cycles("latency", latency_of(e.op), cycles);
    compare_resp("resp", e.expected, resp);
    repeat (int'(e.stall)) begin
      #1;
      compare_flag("req_ready", 1'b0, req_ready);
      @(negedge clock);
      compare_flag("resp_valid", 1'b1, resp_valid);
      compare_resp("resp", e.expected, resp);
    end
    resp_ready = 1'b1;
  endtask

  // Drops the request in flight and presents the next one in the flush cycle
  task automatic flush_and_follow(input stim_t e, input stim_t next);
    repeat (int'(e.flush_after)) begin
      @(negedge clock);
      req_valid = 1'b0;
      compare_flag("resp_valid", 1'b0, resp_valid);
    end
    flush     = 1'b1;
    req.op    = next.op;
    req.a     = next.a;
    req.b     = next.b;
    req_valid = 1'b1;
    #1;
    compare_flag("req_ready", 1'b1, req_ready);
    @(posedge clock);
  endtask

  // ==================================================
  // Main sequence and watchdog
  // ==================================================
  initial begin
    int i;
    bit preaccepted;
    reset      = 1'b1;
    flush      = 1'b0;
    req        = '0;
    req_valid  = 1'b0;
    resp_ready = 1'b0;
    build_table();
    add_random_entries();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset      = 1'b0;
    resp_ready = 1'b1;
    @(negedge clock);
    #1;
    compare_flag("resp_valid", 1'b0, resp_valid);
    compare_flag("req_ready", 1'b1, req_ready);
    @(negedge clock);
    preaccepted = 1'b0;
    for (i = 0; i < stim.size(); i++) begin
      if (!preaccepted) accept_request(stim[i]);
      preaccepted = 1'b0;
      if (stim[i].flush_after != 8'd0) begin
        flush_and_follow(stim[i], stim[i + 1]);
        preaccepted = 1'b1;
      end else begin
        collect_response(stim[i]);
      end
    end
    @(negedge clock);
    $display("Simulation finished: PASS");
    $finish;
  end

  initial begin
    wait (table_ready);
    #((stim.size() * 40 + RESET_CYCLES + 4) * CLK_PERIOD);
    abort_run("Watchdog timeout, the test sequence did not complete in time");
  end

endmodule

`default_nettype wire

/* common/mdu_pkg.sv */
`default_nettype none

package mdu_pkg;

  // ==================================================
  // Widths
  // ==================================================
  localparam int XLEN = 32;

  // ==================================================
  // Operations and states
  // ==================================================
  typedef enum logic [2:0] {
    op_mul    = 3'd0,
    op_mulh   = 3'd1,
    op_mulhsu = 3'd2,
    op_mulhu  = 3'd3,
    op_div    = 3'd4,
    op_divu   = 3'd5,
    op_rem    = 3'd6,
    op_remu   = 3'd7
  } mdu_op_e;

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_mul  = 2'd1,
    st_div  = 2'd2,
    st_done = 2'd3
  } ctrl_state_e;

  // ==================================================
  // Request and response payloads
  // ==================================================
  typedef struct packed {
    mdu_op_e         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
  } mdu_req_t;

  typedef struct packed {
    logic [XLEN-1:0] result;
  } mdu_resp_t;

  typedef struct packed {
    logic            sign;      // Signed division
    logic [XLEN-1:0] dividend;
    logic [XLEN-1:0] divisor;
  } div_req_t;

  typedef struct packed {
    logic [XLEN-1:0] quotient;
    logic [XLEN-1:0] remainder;
  } div_resp_t;

  typedef struct packed {
    logic            a_signed;
    logic            b_signed;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
  } mul_req_t;

endpackage

`default_nettype wire

/* mdu/mdu_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module mdu_ctrl (
  input  wire                         clock,
  input  wire                         reset,
  input  wire                         flush,
  input  wire mdu_pkg::mdu_req_t      req,
  input  wire                         req_valid,
  output logic                        req_ready,
  output mdu_pkg::mdu_resp_t          resp,
  output logic                        resp_valid,
  input  wire                         resp_ready,
  output mdu_pkg::div_req_t           div_req,
  output logic                        div_in_valid,
  input  wire                         div_in_ready,
  input  wire                         div_out_valid,
  output logic                        div_out_ready,
  output mdu_pkg::mul_req_t           mul_req,
  output logic                        mul_in_valid,
  input  wire                         mul_out_valid,
  output mdu_pkg::mdu_op_e            op_q,
  output logic [mdu_pkg::XLEN-1:0]    a_q,
  output logic [mdu_pkg::XLEN-1:0]    b_q,
  input  wire  [mdu_pkg::XLEN-1:0]    result
);

  mdu_pkg::ctrl_state_e state, state_next;
  mdu_pkg::mdu_resp_t   resp_q;
  logic [1:0]           mul_drop;     // Flushed products still in the pipe
  logic                 fire;
  logic                 req_is_div;
  logic                 mul_live;
  logic                 latch;

  // ==================================================
  // Request decode
  // ==================================================
  assign req_is_div = req.op inside {mdu_pkg::op_div, mdu_pkg::op_divu,
                                     mdu_pkg::op_rem, mdu_pkg::op_remu};

  assign req_ready = ((state == mdu_pkg::st_idle) | flush |
                      ((state == mdu_pkg::st_done) & resp_ready)) & div_in_ready;
  assign fire      = req_valid & req_ready;

  assign div_in_valid     = fire & req_is_div;    // Divider loads on the accepting edge
  assign div_req.sign     = (req.op == mdu_pkg::op_div) | (req.op == mdu_pkg::op_rem);
  assign div_req.dividend = req.a;
  assign div_req.divisor  = req.b;

  assign mul_live      = mul_out_valid & (mul_drop == 2'd0);
  assign div_out_ready = (state == mdu_pkg::st_div) & div_out_valid;
  assign latch         = ~flush & (((state == mdu_pkg::st_mul) & mul_live) | div_out_ready);

  // ==================================================
  // State machine
  // ==================================================
  always_comb begin
    state_next = state;
    if (fire) begin
      state_next = req_is_div ? mdu_pkg::st_div : mdu_pkg::st_mul;
    end else if (flush) begin
      state_next = mdu_pkg::st_idle;
    end else begin
      case (state)
        mdu_pkg::st_mul:  if (mul_live) state_next = mdu_pkg::st_done;
        mdu_pkg::st_div:  if (div_out_valid) state_next = mdu_pkg::st_done;
        mdu_pkg::st_done: if (resp_ready) state_next = mdu_pkg::st_idle;
        default:          state_next = state;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= mdu_pkg::st_idle;
      mul_in_valid <= 1'b0;
      mul_drop     <= 2'd0;
    end else begin
      state        <= state_next;
      mul_in_valid <= fire & ~req_is_div;
      // A flushed multiply keeps moving and its product gets skipped
      mul_drop     <= mul_drop
                      + {1'b0, flush & (state == mdu_pkg::st_mul) & ~mul_live}
                      - {1'b0, mul_out_valid & (mul_drop != 2'd0)};
    end
  end

  // Operands for the multiplier and the formatter
  always_ff @(posedge clock) begin
    if (fire) begin
      op_q             <= req.op;
      a_q              <= req.a;
      b_q              <= req.b;
      mul_req.a        <= req.a;
      mul_req.b        <= req.b;
      mul_req.a_signed <= (req.op == mdu_pkg::op_mulh) | (req.op == mdu_pkg::op_mulhsu);
      mul_req.b_signed <= req.op == mdu_pkg::op_mulh;
    end
    if (latch) begin
      resp_q.result <= result;
    end
  end

  assign resp       = resp_q;
  assign resp_valid = state == mdu_pkg::st_done;

  // ==================================================
  // Checks
  // ==================================================
  resp_hold_a : assert property (@(posedge clock) disable iff (reset)
    resp_valid && !resp_ready && !flush |=> resp_valid && $stable(resp));

  div_issue_a : assert property (@(posedge clock) disable iff (reset)
    div_in_valid |-> !div_out_valid);

endmodule

`default_nettype wire

/* mdu/mdu_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module mdu_divider (
  input  wire                    clock,
  input  wire                    reset,
  input  wire                    flush,
  input  wire                    in_valid,
  output logic                   in_ready,
  input  wire mdu_pkg::div_req_t in,
  output logic                   out_valid,
  input  wire                    out_ready,
  output mdu_pkg::div_resp_t     out
);

  localparam int W = mdu_pkg::XLEN;
  localparam logic [5:0] step_idle  = 6'd32;
  localparam logic [5:0] step_hold  = 6'd63;
  localparam logic [5:0] step_first = 6'd31;

  logic [5:0]     step, step_next;    // Counts down and wraps into hold
  logic [2*W-1:0] acc, acc_next;      // Partial remainder and shifted dividend
  logic [W-1:0]   dvsr, dvsr_next;
  logic [W-1:0]   quot, quot_next;
  logic           q_neg, q_neg_next;
  logic           r_neg, r_neg_next;
  logic           a_neg, b_neg;
  logic           fire;
  logic           idle, hold;
  logic [W:0]     trial;

  assign idle  = step == step_idle;
  assign hold  = step == step_hold;
  assign fire  = in_valid & in_ready;
  assign a_neg = in.sign & in.dividend[W-1];
  assign b_neg = in.sign & in.divisor[W-1];
  assign trial = acc[2*W-1:W-1] - {1'b0, dvsr};

  always_comb begin
    step_next  = step;
    acc_next   = acc;
    dvsr_next  = dvsr;
    quot_next  = quot;
    q_neg_next = q_neg;
    r_neg_next = r_neg;
    if (fire) begin
      step_next  = step_first;
      acc_next   = {{W{1'b0}}, a_neg ? -in.dividend : in.dividend};
      dvsr_next  = b_neg ? -in.divisor : in.divisor;
      q_neg_next = a_neg ^ b_neg;
      r_neg_next = a_neg;       // Remainder takes the dividend sign
    end else if (hold) begin
      if (flush | out_ready) begin
        step_next = step_idle;
      end
    end else if (!idle) begin
      if (flush) begin
        step_next = step_idle;
      end else begin
        step_next = step - 6'd1;
        acc_next  = trial[W] ? {acc[2*W-2:0], 1'b0}
                             : {trial[W-1:0], acc[W-2:0], 1'b0};
        quot_next = {quot[W-2:0], ~trial[W]};
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      step <= step_idle;
    end else begin
      step <= step_next;
    end
  end

  always_ff @(posedge clock) begin
    acc   <= acc_next;
    dvsr  <= dvsr_next;
    quot  <= quot_next;
    q_neg <= q_neg_next;
    r_neg <= r_neg_next;
  end

  assign in_ready      = idle | flush | (out_ready & hold);
  assign out_valid     = hold & ~flush;
  assign out.quotient  = q_neg ? -quot : quot;
  assign out.remainder = r_neg ? -acc[2*W-1:W] : acc[2*W-1:W];

  out_hold_a : assert property (@(posedge clock) disable iff (reset)
    out_valid && !out_ready |=> hold && $stable(out));

endmodule

`default_nettype wire

/* mdu/mdu_multiplier.sv */
`timescale 1ns/1ps
`default_nettype none

module mdu_multiplier (
  input  wire                    clock,
  input  wire                    reset,
  input  wire                    in_valid,
  input  wire mdu_pkg::mul_req_t in,
  output logic                   out_valid,
  output logic [63:0]            product
);

  localparam int W = mdu_pkg::XLEN;

  logic [W:0]         a_ext, b_ext;   // 33 bit operands
  logic signed [16:0] a_hi, a_lo, b_hi, b_lo;
  logic signed [33:0] pp_hh, pp_hl, pp_lh, pp_ll;
  logic signed [33:0] s1_hh, s1_hl, s1_lh, s1_ll;
  logic               s1_valid;
  logic [63:0]        sum;

  // ==================================================
  // Stage one, partial products
  // ==================================================
  assign a_ext = {in.a_signed & in.a[W-1], in.a};
  assign b_ext = {in.b_signed & in.b[W-1], in.b};

  assign a_hi = a_ext[32:16];                // Signed upper slice
  assign a_lo = {1'b0, a_ext[15:0]};         // Unsigned lower slice
  assign b_hi = b_ext[32:16];
  assign b_lo = {1'b0, b_ext[15:0]};

  assign pp_hh = a_hi * b_hi;
  assign pp_hl = a_hi * b_lo;
  assign pp_lh = a_lo * b_hi;
  assign pp_ll = a_lo * b_lo;

  always_ff @(posedge clock) begin
    s1_hh <= pp_hh;
    s1_hl <= pp_hl;
    s1_lh <= pp_lh;
    s1_ll <= pp_ll;
  end

  // ==================================================
  // Stage two, final sum
  // ==================================================
  assign sum = ({{30{s1_hh[33]}}, s1_hh} << 32)
             + ({{30{s1_hl[33]}}, s1_hl} << 16)
             + ({{30{s1_lh[33]}}, s1_lh} << 16)
             + {{30{s1_ll[33]}}, s1_ll};

  always_ff @(posedge clock) begin
    product <= sum;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= in_valid;
      out_valid <= s1_valid;
    end
  end

endmodule

`default_nettype wire

/* rtl/mdu_result_fmt.sv */
`timescale 1ns/1ps
`default_nettype none

module mdu_result_fmt (
  input  wire mdu_pkg::mdu_op_e        op,
  input  wire [mdu_pkg::XLEN-1:0]      a,
  input  wire [mdu_pkg::XLEN-1:0]      b,
  input  wire [63:0]                   product,
  input  wire mdu_pkg::div_resp_t      div,
  output logic [mdu_pkg::XLEN-1:0]     result
);

  localparam int W = mdu_pkg::XLEN;

  logic div_zero;
  logic overflow;

  assign div_zero = b == '0;
  // Most negative value over minus one
  assign overflow = (a == {1'b1, {(W-1){1'b0}}}) && (b == {W{1'b1}});

  always_comb begin
    case (op)
      mdu_pkg::op_mul: result = product[W-1:0];
      mdu_pkg::op_mulh,
      mdu_pkg::op_mulhsu,
      mdu_pkg::op_mulhu: result = product[2*W-1:W];
      mdu_pkg::op_div: begin
        if (div_zero) begin
          result = {W{1'b1}};
        end else if (overflow) begin
          result = a;
        end else begin
          result = div.quotient;
        end
      end
      mdu_pkg::op_divu: result = div_zero ? {W{1'b1}} : div.quotient;
      mdu_pkg::op_rem: begin
        if (div_zero) begin
          result = a;
        end else if (overflow) begin
          result = '0;
        end else begin
          result = div.remainder;
        end
      end
      mdu_pkg::op_remu: result = div_zero ? a : div.remainder;
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/mdu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mdu_top (
  input  wire                    clock,
  input  wire                    reset,
  input  wire                    flush,
  input  wire mdu_pkg::mdu_req_t req,
  input  wire                    req_valid,
  output logic                   req_ready,
  output mdu_pkg::mdu_resp_t     resp,
  output logic                   resp_valid,
  input  wire                    resp_ready
);

  mdu_pkg::div_req_t          div_req;
  mdu_pkg::div_resp_t         div_resp;
  mdu_pkg::mul_req_t          mul_req;
  mdu_pkg::mdu_op_e           op_q;
  logic [mdu_pkg::XLEN-1:0]   a_q, b_q;
  logic [mdu_pkg::XLEN-1:0]   result;
  logic [63:0]                product;
  logic                       div_in_valid, div_in_ready;
  logic                       div_out_valid, div_out_ready;
  logic                       mul_in_valid, mul_out_valid;

  mdu_ctrl mdu_ctrl_inst (
    .clock         (clock),
    .reset         (reset),
    .flush         (flush),
    .req           (req),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .resp          (resp),
    .resp_valid    (resp_valid),
    .resp_ready    (resp_ready),
    .div_req       (div_req),
    .div_in_valid  (div_in_valid),
    .div_in_ready  (div_in_ready),
    .div_out_valid (div_out_valid),
    .div_out_ready (div_out_ready),
    .mul_req       (mul_req),
    .mul_in_valid  (mul_in_valid),
    .mul_out_valid (mul_out_valid),
    .op_q          (op_q),
    .a_q           (a_q),
    .b_q           (b_q),
    .result        (result)
  );

  mdu_divider mdu_divider_inst (
    .clock     (clock),
    .reset     (reset),
    .flush     (flush),
    .in_valid  (div_in_valid),
    .in_ready  (div_in_ready),
    .in        (div_req),
    .out_valid (div_out_valid),
    .out_ready (div_out_ready),
    .out       (div_resp)
  );

  mdu_multiplier mdu_multiplier_inst (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (mul_in_valid),
    .in        (mul_req),
    .out_valid (mul_out_valid),
    .product   (product)
  );

  mdu_result_fmt mdu_result_fmt_inst (
    .op      (op_q),
    .a       (a_q),
    .b       (b_q),
    .product (product),
    .div     (div_resp),
    .result  (result)
  );

endmodule

`default_nettype wire

/* vlog.f */
+incdir+bench
common/mdu_pkg.sv
rtl/mdu_result_fmt.sv
mdu/mdu_divider.sv
mdu/mdu_multiplier.sv
mdu/mdu_ctrl.sv
rtl/mdu_top.sv
bench/mdu_tb.sv
